/* rv_defs.svh */
// RV64IM decode front end shared parameters
// data, instruction and register index widths, reset pc, queue depth

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

///////////////////////////////////////////////////////////////////////
// datapath widths
///////////////////////////////////////////////////////////////////////

`define XLEN 64      // data and immediate width
`define ILEN 32      // instruction word width
`define REG_ID_W 5   // x0..x31

///////////////////////////////////////////////////////////////////////
// fetch and queue
///////////////////////////////////////////////////////////////////////

// pc given to the first word after reset
`define RESET_PC 64'h8000_0000

// instruction queue entries
`define QUEUE_DEPTH 4

`endif

/* rv_isa_pkg.sv */
// RV64IM ISA encoding types
// major opcodes, funct7 codes and the two views of an instruction word

`default_nettype none

package rv_isa_pkg;

  `include "rv_defs.svh"

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    LOAD      = 7'b0000011,
    OP_IMM    = 7'b0010011,
    AUIPC     = 7'b0010111,
    OP_IMM_32 = 7'b0011011,
    STORE     = 7'b0100011,
    OP        = 7'b0110011,
    LUI       = 7'b0110111,
    OP_32     = 7'b0111011,
    BRANCH    = 7'b1100011,
    JALR      = 7'b1100111,
    JAL       = 7'b1101111,
    SYSTEM    = 7'b1110011
  } opcode_e;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // R, I and S formats read the word as plain fields
  typedef struct packed {
    logic [6:0]           funct7;
    logic [`REG_ID_W-1:0] rs2;
    logic [`REG_ID_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [`REG_ID_W-1:0] rd;
    opcode_e              opcode;
  } rsi_view_t;

  // B, U and J formats scatter their immediate bits
  typedef struct packed {
    logic                 b31;     // sign bit in every format
    logic [5:0]           b30_25;
    logic [3:0]           b24_21;
    logic                 b20;
    logic [7:0]           b19_12;
    logic [`REG_ID_W-1:0] rd;      // holds imm[4:1|11] for branches
    opcode_e              opcode;
  } buj_view_t;

  typedef union packed {
    rsi_view_t rsi;
    buj_view_t buj;
  } inst_word_u;

endpackage

`default_nettype wire

/* rv_ctrl_pkg.sv */
// decoded control types for the decode front end
// ALU operation groups, access width, control flags and pipeline packets

`default_nettype none

package rv_ctrl_pkg;

  `include "rv_defs.svh"

  // one value per ALU operation group
  typedef enum logic [5:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_LT, ALU_LTU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_OUT_IMM,                                // lui
    ALU_EQ, ALU_NE, ALU_GE, ALU_GEU,            // branch compares
    ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, ALU_MULW,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
    ALU_DIVW, ALU_DIVUW, ALU_REMW, ALU_REMUW
  } alu_op_e;

  typedef enum logic [2:0] {W_NONE, W8, W16, W32, W64} width_e;

  typedef struct packed {
    logic need_imm;     // second operand is the immediate
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_auipc;
    logic is_ebreak;
    logic is_unsigned;  // zero-extending load
    logic reg_wen;
    logic mem_wen;
    logic illegal;
  } dec_flags_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    rv_isa_pkg::inst_word_u inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [`XLEN-1:0]     pc;
    logic [`REG_ID_W-1:0] rd;
    logic [`REG_ID_W-1:0] rs1;
    logic [`REG_ID_W-1:0] rs2;
    logic [`XLEN-1:0]     imm;
    alu_op_e              alu_op;
    width_e               width;
    dec_flags_t           flags;
  } dec_inst_t;

endpackage

`default_nettype wire

/* fetch_unit.sv */
// fetch unit
// tags each strobed instruction word with its pc and pushes the
// packet into the instruction queue one cycle later

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module fetch_unit
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       in_valid,   // one word per strobe
  input  inst_word_u in_inst,
  output logic       push,
  output fetch_pkt_t push_pkt
);

  localparam logic [`XLEN-1:0] PC_STEP = 4;

  logic [`XLEN-1:0] pc_q;   // pc of the next word in the stream

  // pc advances on every strobe, even if the queue later drops the word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= `RESET_PC;
      push <= 1'b0;
    end else begin
      push <= in_valid;
      if (in_valid) pc_q <= pc_q + PC_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      push_pkt.pc   <= pc_q;
      push_pkt.inst <= in_inst;
    end
  end

endmodule

`default_nettype wire

/* inst_queue.sv */
// instruction queue
// show-ahead circular FIFO of fetch packets, head is valid combinationally
// a push into a full queue is dropped and sets a sticky overflow flag

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module inst_queue
  import rv_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push,
  input  fetch_pkt_t push_pkt,
  input  logic       pop,
  output fetch_pkt_t head,
  output logic       not_empty,
  output logic       overflow
);

  localparam int DEPTH = `QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  fetch_pkt_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;    // occupancy, 0..DEPTH
  logic             full;
  logic             do_push;
  logic             do_pop;

  // wrap for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (count == (PTR_W + 1)'(DEPTH));
  assign not_empty = (count != '0);
  assign do_push   = push & ~full;
  assign do_pop    = pop & not_empty;
  assign head      = mem[rd_ptr];

  ///////////////////////////////////////////////////////////////////////
  // pointers, occupancy and overflow
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // both or neither
      endcase
      if (push && full) overflow <= 1'b1;   // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_pkt;
  end

endmodule

`default_nettype wire

/* decoder.sv */
// RV64IM instruction decoder
// purely combinational, splits a word into register indices, immediate,
// ALU operation group, access width and control flags

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module decoder
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  inst_word_u inst,
  output dec_inst_t  dec    // pc left at zero, filled in by decode stage
);

  opcode_e    opc;
  logic [2:0] f3;
  logic [6:0] f7;

  assign opc = inst.rsi.opcode;
  assign f3  = inst.rsi.funct3;
  assign f7  = inst.rsi.funct7;

  ///////////////////////////////////////////////////////////////////////
  // opcode classes
  ///////////////////////////////////////////////////////////////////////

  wire op_imm    = (opc == OP_IMM);
  wire op_imm_32 = (opc == OP_IMM_32);
  wire op_op     = (opc == OP);
  wire op_32     = (opc == OP_32);
  wire op_lui    = (opc == LUI);
  wire op_auipc  = (opc == AUIPC);
  wire op_jal    = (opc == JAL);
  wire op_jalr   = (opc == JALR);
  wire op_branch = (opc == BRANCH);
  wire op_load   = (opc == LOAD);
  wire op_store  = (opc == STORE);
  wire op_system = (opc == SYSTEM);

  wire f7_base = (f7 == F7_BASE);
  wire f7_alt  = (f7 == F7_ALT);
  wire f7_md   = (f7 == F7_MULDIV);

  // RV64 shifts take a 6 bit shamt, so only funct7[6:1] is the code
  wire sh_base = (f7[6:1] == F7_BASE[6:1]);
  wire sh_alt  = (f7[6:1] == F7_ALT[6:1]);

  ///////////////////////////////////////////////////////////////////////
  // individual instructions
  ///////////////////////////////////////////////////////////////////////

  wire addi  = op_imm & (f3 == 3'b000);
  wire slti  = op_imm & (f3 == 3'b010);
  wire sltiu = op_imm & (f3 == 3'b011);
  wire xori  = op_imm & (f3 == 3'b100);
  wire ori   = op_imm & (f3 == 3'b110);
  wire andi  = op_imm & (f3 == 3'b111);
  wire slli  = op_imm & (f3 == 3'b001) & sh_base;
  wire srli  = op_imm & (f3 == 3'b101) & sh_base;
  wire srai  = op_imm & (f3 == 3'b101) & sh_alt;

  wire add_r = op_op & (f3 == 3'b000) & f7_base;
  wire sub_r = op_op & (f3 == 3'b000) & f7_alt;
  wire sll_r = op_op & (f3 == 3'b001) & f7_base;
  wire slt_r = op_op & (f3 == 3'b010) & f7_base;
  wire sltu  = op_op & (f3 == 3'b011) & f7_base;
  wire xor_r = op_op & (f3 == 3'b100) & f7_base;
  wire srl_r = op_op & (f3 == 3'b101) & f7_base;
  wire sra_r = op_op & (f3 == 3'b101) & f7_alt;
  wire or_r  = op_op & (f3 == 3'b110) & f7_base;
  wire and_r = op_op & (f3 == 3'b111) & f7_base;

  wire addw_g = (op_imm_32 & (f3 == 3'b000)) | (op_32 & (f3 == 3'b000) & f7_base);
  wire subw   = op_32 & (f3 == 3'b000) & f7_alt;
  wire sllw_g = (op_imm_32 | op_32) & (f3 == 3'b001) & f7_base;
  wire srlw_g = (op_imm_32 | op_32) & (f3 == 3'b101) & f7_base;
  wire sraw_g = (op_imm_32 | op_32) & (f3 == 3'b101) & f7_alt;

  wire md    = op_op & f7_md;   // M extension, funct3 picks the op
  wire md_w  = op_32 & f7_md;

  wire beq  = op_branch & (f3 == 3'b000);
  wire bne  = op_branch & (f3 == 3'b001);
  wire blt  = op_branch & (f3 == 3'b100);
  wire bge  = op_branch & (f3 == 3'b101);
  wire bltu = op_branch & (f3 == 3'b110);
  wire bgeu = op_branch & (f3 == 3'b111);

  wire sz8   = (op_load | op_store) & (f3[1:0] == 2'b00);   // lb lbu sb
  wire sz16  = (op_load | op_store) & (f3[1:0] == 2'b01);
  wire sz32  = (op_load | op_store) & (f3[1:0] == 2'b10);
  wire sz64  = (op_load | op_store) & (f3 == 3'b011);
  wire ld_u  = op_load & f3[2] & (f3 != 3'b111);            // lbu lhu lwu

  wire ebreak = op_system & (f3 == 3'b000) & f7_base & (inst.rsi.rs2 == 5'd1);

  wire known = op_imm | op_imm_32 | op_op | op_32 | op_lui | op_auipc | op_jal
             | op_jalr | op_branch | op_load | op_store | op_system;

  ///////////////////////////////////////////////////////////////////////
  // output assembly
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    dec     = '0;
    dec.rd  = inst.rsi.rd;
    dec.rs1 = inst.rsi.rs1;
    dec.rs2 = inst.rsi.rs2;

    // immediate by format, R type stays zero
    if (op_imm | op_imm_32 | op_load | op_jalr)
      dec.imm = {{(`XLEN-12){f7[6]}}, f7, inst.rsi.rs2};
    else if (op_store)
      dec.imm = {{(`XLEN-12){f7[6]}}, f7, inst.rsi.rd};
    else if (op_branch)
      dec.imm = {{(`XLEN-12){inst.buj.b31}}, inst.buj.rd[0], inst.buj.b30_25,
                 inst.buj.rd[4:1], 1'b0};
    else if (op_lui | op_auipc)
      dec.imm = {{(`XLEN-32){inst.buj.b31}}, inst.buj.b31, inst.buj.b30_25,
                 inst.buj.b24_21, inst.buj.b20, inst.buj.b19_12, 12'b0};
    else if (op_jal)
      dec.imm = {{(`XLEN-20){inst.buj.b31}}, inst.buj.b19_12, inst.buj.b20,
                 inst.buj.b30_25, inst.buj.b24_21, 1'b0};

    if (addi | add_r | op_auipc | op_jal | op_jalr | op_load | op_store)
      dec.alu_op = ALU_ADD;
    else if (sub_r)         dec.alu_op = ALU_SUB;
    else if (slti | slt_r | blt)   dec.alu_op = ALU_LT;
    else if (sltiu | sltu | bltu)  dec.alu_op = ALU_LTU;
    else if (andi | and_r)  dec.alu_op = ALU_AND;
    else if (ori | or_r)    dec.alu_op = ALU_OR;
    else if (xori | xor_r)  dec.alu_op = ALU_XOR;
    else if (slli | sll_r)  dec.alu_op = ALU_SLL;
    else if (srli | srl_r)  dec.alu_op = ALU_SRL;
    else if (srai | sra_r)  dec.alu_op = ALU_SRA;
    else if (op_lui)        dec.alu_op = ALU_OUT_IMM;
    else if (beq)           dec.alu_op = ALU_EQ;
    else if (bne)           dec.alu_op = ALU_NE;
    else if (bge)           dec.alu_op = ALU_GE;
    else if (bgeu)          dec.alu_op = ALU_GEU;
    else if (addw_g)        dec.alu_op = ALU_ADDW;
    else if (subw)          dec.alu_op = ALU_SUBW;
    else if (sllw_g)        dec.alu_op = ALU_SLLW;
    else if (srlw_g)        dec.alu_op = ALU_SRLW;
    else if (sraw_g)        dec.alu_op = ALU_SRAW;
    else if (md) begin
      case (f3)
        3'b000:  dec.alu_op = ALU_MUL;
        3'b001:  dec.alu_op = ALU_MULH;
        3'b010:  dec.alu_op = ALU_MULHSU;
        3'b011:  dec.alu_op = ALU_MULHU;
        3'b100:  dec.alu_op = ALU_DIV;
        3'b101:  dec.alu_op = ALU_DIVU;
        3'b110:  dec.alu_op = ALU_REM;
        default: dec.alu_op = ALU_REMU;
      endcase
    end else if (md_w) begin
      case (f3)
        3'b000:  dec.alu_op = ALU_MULW;
        3'b100:  dec.alu_op = ALU_DIVW;
        3'b101:  dec.alu_op = ALU_DIVUW;
        3'b110:  dec.alu_op = ALU_REMW;
        3'b111:  dec.alu_op = ALU_REMUW;
        default: dec.alu_op = ALU_NONE;   // no mulh variants in RV64M word ops
      endcase
    end

    if (sz8)       dec.width = W8;
    else if (sz16) dec.width = W16;
    else if (sz32) dec.width = W32;
    else if (sz64) dec.width = W64;

    dec.flags.need_imm    = op_imm | op_imm_32 | op_lui | op_auipc | op_store
                          | op_jal | op_jalr | op_load;
    dec.flags.is_load     = op_load;
    dec.flags.is_store    = op_store;
    dec.flags.is_branch   = op_branch;
    dec.flags.is_jal      = op_jal;
    dec.flags.is_jalr     = op_jalr;
    dec.flags.is_auipc    = op_auipc;
    dec.flags.is_ebreak   = ebreak;
    dec.flags.is_unsigned = ld_u;
    dec.flags.reg_wen     = op_imm | op_imm_32 | op_lui | op_auipc | op_op | op_32
                          | op_jal | op_jalr | op_load;
    dec.flags.mem_wen     = op_store;
    // all-zero word passes as a bubble
    dec.flags.illegal     = ~(known | (inst == {`ILEN{1'b0}}));
  end

endmodule

`default_nettype wire

/* decode_stage.sv */
// decode stage
// pops the queue head whenever not held, decodes it and registers the
// result as a one-cycle strobe, counts illegal words (saturating)

`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  fetch_pkt_t  head,
  input  logic        not_empty,
  input  logic        hold,        // level from the execute side
  output logic        pop,
  output logic        out_valid,
  output dec_inst_t   out_inst,
  output logic [15:0] illegal_count
);

  dec_inst_t dec;
  dec_inst_t dec_pc;   // decoder result with the head's pc

  assign pop = not_empty & ~hold;

  decoder u_decoder (
    .inst (head.inst),
    .dec  (dec)
  );

  always_comb begin
    dec_pc    = dec;
    dec_pc.pc = head.pc;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid     <= 1'b0;
      illegal_count <= '0;
    end else begin
      out_valid <= pop;
      if (pop && dec.flags.illegal && (illegal_count != 16'hffff))
        illegal_count <= illegal_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) out_inst <= dec_pc;   // held between strobes
  end

endmodule

`default_nettype wire

/* decode_top.sv */
// decode front end top level
// fetch unit feeds the instruction queue, decode stage drains it

`timescale 1ns/1ps
`default_nettype none

module decode_top
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  input  inst_word_u  in_inst,
  input  logic        hold,
  output logic        out_valid,
  output dec_inst_t   out_inst,
  output logic        overflow,
  output logic [15:0] illegal_count
);

  logic       push;
  fetch_pkt_t push_pkt;
  logic       pop;
  fetch_pkt_t head;
  logic       not_empty;

  fetch_unit u_fetch (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .push     (push),
    .push_pkt (push_pkt)
  );

  inst_queue u_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_pkt  (push_pkt),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .overflow  (overflow)
  );

  decode_stage u_decode (
    .clk           (clk),
    .arst_n        (arst_n),
    .head          (head),
    .not_empty     (not_empty),
    .hold          (hold),
    .pop           (pop),
    .out_valid     (out_valid),
    .out_inst      (out_inst),
    .illegal_count (illegal_count)
  );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// testbench clock and reset
// 4 ns clock, reset held low for the first 4 rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic arst_n
);

  localparam real HALF_PERIOD = 2.0;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;   // release away from the edge
  end

endmodule

`default_nettype wire

/* decode_assert.sv */
// decode front end checks
// concurrent assertions on the output strobe, hold and overflow

`timescale 1ns/1ps
`default_nettype none

module decode_assert
  import rv_ctrl_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input logic      hold,
  input logic      out_valid,
  input dec_inst_t out_inst,
  input logic      overflow
);

  // hold blocks the pop, so no strobe follows a held cycle
  a_hold_stops_output: assert property (
    @(posedge clk) disable iff (!arst_n) hold |=> !out_valid
  ) else $error("out_valid high in the cycle after hold was high");

  a_overflow_sticky: assert property (
    @(posedge clk) disable iff (!arst_n) overflow |=> overflow
  ) else $error("overflow fell without a reset");

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n) out_valid |-> (out_inst.pc[1:0] == 2'b00)
  ) else $error("decoded pc is not word aligned");

endmodule

`default_nettype wire

/* decode_tb.sv */
// decode front end testbench
// table of instruction words with expected decode, a model queue of
// expected results, plus hold, overflow and reset state checks

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module decode_tb
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
();

  localparam int TABLE_N     = 25;
  localparam int HOLD_WAIT   = 6;                  // cycles spent held
  localparam int DRAIN_LIMIT = `QUEUE_DEPTH + 8;
  localparam int STROBES     = TABLE_N + 2 * `QUEUE_DEPTH + 2;
  localparam int CYCLE_LIMIT = 3 * STROBES + 2 * HOLD_WAIT + 50;

  // flag bits, need_imm at the top down to illegal
  localparam logic [11:0] F_IMM   = 12'h800;
  localparam logic [11:0] F_LD    = 12'h400;
  localparam logic [11:0] F_ST    = 12'h200;
  localparam logic [11:0] F_BR    = 12'h100;
  localparam logic [11:0] F_JAL   = 12'h080;
  localparam logic [11:0] F_JALR  = 12'h040;
  localparam logic [11:0] F_AUIPC = 12'h020;
  localparam logic [11:0] F_EBRK  = 12'h010;
  localparam logic [11:0] F_UNS   = 12'h008;
  localparam logic [11:0] F_RWEN  = 12'h004;
  localparam logic [11:0] F_MWEN  = 12'h002;
  localparam logic [11:0] F_ILL   = 12'h001;

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  inst_word_u  in_inst;
  logic        hold;
  logic        out_valid;
  dec_inst_t   out_inst;
  logic        overflow;
  logic [15:0] illegal_count;

  logic [31:0] tbl_word  [TABLE_N];
  logic        tbl_rtype [TABLE_N];   // register fields come from the rng
  alu_op_e     tbl_alu   [TABLE_N];
  width_e      tbl_width [TABLE_N];
  logic [11:0] tbl_flags [TABLE_N];
  logic [63:0] tbl_imm   [TABLE_N];
  int          n_entries;
  int          n_illegal;

  dec_inst_t   exp_q[$];              // expected outputs in stream order
  dec_inst_t   mon_exp;
  logic [31:0] rng_state;
  int          strobe_idx;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  logic        quiet;                 // no output allowed while set

  tb_clkgen u_clkgen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  decode_top dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_inst       (in_inst),
    .hold          (hold),
    .out_valid     (out_valid),
    .out_inst      (out_inst),
    .overflow      (overflow),
    .illegal_count (illegal_count)
  );

  bind decode_top decode_assert u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .hold      (hold),
    .out_valid (out_valid),
    .out_inst  (out_inst),
    .overflow  (overflow)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_entry(input logic [31:0] w, input logic r, input alu_op_e op,
                           input width_e wd, input logic [11:0] f, input logic [63:0] imm);
    tbl_word[n_entries]  = w;
    tbl_rtype[n_entries] = r;
    tbl_alu[n_entries]   = op;
    tbl_width[n_entries] = wd;
    tbl_flags[n_entries] = f;
    tbl_imm[n_entries]   = imm;
    if ((f & F_ILL) != 12'h0) n_illegal++;
    n_entries++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic load_table();
    add_entry(32'h00000033, 1, ALU_ADD,    W_NONE, F_RWEN, 64'h0);   // add
    add_entry(32'h40000033, 1, ALU_SUB,    W_NONE, F_RWEN, 64'h0);   // sub
    add_entry(32'h00003033, 1, ALU_LTU,    W_NONE, F_RWEN, 64'h0);   // sltu
    add_entry(32'h00004033, 1, ALU_XOR,    W_NONE, F_RWEN, 64'h0);   // xor
    add_entry(32'h40005033, 1, ALU_SRA,    W_NONE, F_RWEN, 64'h0);   // sra
    add_entry(32'h4000003b, 1, ALU_SUBW,   W_NONE, F_RWEN, 64'h0);   // subw
    add_entry(32'h02002033, 1, ALU_MULHSU, W_NONE, F_RWEN, 64'h0);   // mulhsu
    add_entry(32'h0200703b, 1, ALU_REMUW,  W_NONE, F_RWEN, 64'h0);   // remuw
    add_entry(32'hfff30293, 0, ALU_ADD,  W_NONE, F_IMM | F_RWEN, '1);         // addi -1
    add_entry(32'h42315093, 0, ALU_SRA,  W_NONE, F_IMM | F_RWEN, 64'h423);    // srai 35
    add_entry(32'h7f027193, 0, ALU_AND,  W_NONE, F_IMM | F_RWEN, 64'h7f0);
    add_entry(32'h00c4039b, 0, ALU_ADDW, W_NONE, F_IMM | F_RWEN, 64'hc);      // addiw
    add_entry(32'hffc54483, 0, ALU_ADD, W8, F_IMM | F_LD | F_UNS | F_RWEN,
              64'hffff_ffff_ffff_fffc);                                       // lbu -4
    add_entry(32'h00813583, 0, ALU_ADD, W64, F_IMM | F_LD | F_RWEN, 64'h8);   // ld
    add_entry(32'h00532a23, 0, ALU_ADD, W32, F_IMM | F_ST | F_MWEN, 64'h14);  // sw
    add_entry(32'hfe209ce3, 0, ALU_NE,  W_NONE, F_BR, 64'hffff_ffff_ffff_fff8);
    add_entry(32'h0041f863, 0, ALU_GEU, W_NONE, F_BR, 64'h10);
    add_entry(32'h123452b7, 0, ALU_OUT_IMM, W_NONE, F_IMM | F_RWEN, 64'h1234_5000);
    add_entry(32'h80000317, 0, ALU_ADD, W_NONE, F_IMM | F_AUIPC | F_RWEN,
              64'hffff_ffff_8000_0000);
    add_entry(32'h001000ef, 0, ALU_ADD,  W_NONE, F_IMM | F_JAL | F_RWEN, 64'h800);
    add_entry(32'h00008067, 0, ALU_ADD,  W_NONE, F_IMM | F_JALR | F_RWEN, 64'h0);
    add_entry(32'h00100073, 0, ALU_NONE, W_NONE, F_EBRK, 64'h0);     // ebreak
    add_entry(32'h1234500b, 0, ALU_NONE, W_NONE, F_ILL, 64'h0);      // custom-0
    add_entry(32'h00000000, 0, ALU_NONE, W_NONE, 12'h0, 64'h0);      // bubble
    add_entry(32'hffffffff, 0, ALU_NONE, W_NONE, F_ILL, 64'h0);
  endtask

  // strobes one table word and queues its expected decode
  task automatic send_entry(input int i, input logic expect_out);
    logic [31:0] w;
    dec_inst_t   e;
    w = tbl_word[i];
    if (tbl_rtype[i]) begin
      rng_state = xorshift32(rng_state);
      w[11:7]   = rng_state[4:0];
      w[19:15]  = rng_state[12:8];
      w[24:20]  = rng_state[20:16];
    end
    e        = '0;
    e.pc     = `RESET_PC + 64'(4 * strobe_idx);   // dropped words still take a pc
    e.rd     = w[11:7];
    e.rs1    = w[19:15];
    e.rs2    = w[24:20];
    e.imm    = tbl_imm[i];
    e.alu_op = tbl_alu[i];
    e.width  = tbl_width[i];
    e.flags  = tbl_flags[i];
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    in_inst  = w;
    strobe_idx++;
    if (expect_out) exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  task automatic set_hold(input logic v);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    hold     = v;
    quiet    = v;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    idle(1);
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      idle(1);
      waited++;
    end
    if (exp_q.size() != 0) begin
      foreach (exp_q[k]) begin
        errors++;
        $display("missing output: word at pc 0x%h never came out of decode", exp_q[k].pc);
      end
      exp_q.delete();
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h (pc 0x%h)", name, got, exp, mon_exp.pc);
    end
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, errors - err_mark);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor and watchdog
  //////////////////////////////////////////////////////////////////////

  // sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      if (quiet) begin
        errors++;
        $display("output strobe appeared while hold was high (pc 0x%h)", out_inst.pc);
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected output strobe with no word pending (pc 0x%h)", out_inst.pc);
      end else begin
        mon_exp = exp_q.pop_front();
        check_field("pc", out_inst.pc, mon_exp.pc);
        check_field("rd", out_inst.rd, mon_exp.rd);
        check_field("rs1", out_inst.rs1, mon_exp.rs1);
        check_field("rs2", out_inst.rs2, mon_exp.rs2);
        check_field("imm", out_inst.imm, mon_exp.imm);
        check_field("alu_op", out_inst.alu_op, mon_exp.alu_op);
        check_field("width", out_inst.width, mon_exp.width);
        check_field("flags", out_inst.flags, mon_exp.flags);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    int err_mark;
    in_valid     = 1'b0;
    in_inst      = '0;
    hold         = 1'b0;
    quiet        = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;
    strobe_idx   = 0;
    n_entries    = 0;
    n_illegal    = 0;
    rng_state    = 32'd43651;
    load_table();

    wait (arst_n === 1'b1);
    err_mark = errors;
    idle(1);
    if (out_valid !== 1'b0) begin
      errors++;
      $display("FAIL out_valid: got 0x%h, expected 0x0", out_valid);
    end
    if (overflow !== 1'b0) begin
      errors++;
      $display("FAIL overflow: got 0x%h, expected 0x0", overflow);
    end
    if (illegal_count !== 16'h0) begin
      errors++;
      $display("FAIL illegal_count: got 0x%h, expected 0x0", illegal_count);
    end
    finish_test("reset state", err_mark);

    // every table word back to back, hold low
    err_mark = errors;
    for (int i = 0; i < TABLE_N; i++) send_entry(i, 1'b1);
    wait_drain();
    finish_test("field decode and pc order", err_mark);

    err_mark = errors;
    if (illegal_count !== 16'(n_illegal)) begin
      errors++;
      $display("FAIL illegal_count: got 0x%h, expected 0x%h", illegal_count, 16'(n_illegal));
    end
    finish_test("illegal words", err_mark);

    // fill the queue exactly while held
    err_mark = errors;
    set_hold(1'b1);
    for (int k = 0; k < `QUEUE_DEPTH; k++) send_entry((8 + k) % TABLE_N, 1'b1);
    idle(HOLD_WAIT);
    set_hold(1'b0);
    wait_drain();
    if (overflow !== 1'b0) begin
      errors++;
      $display("FAIL overflow: got 0x%h, expected 0x0", overflow);
    end
    finish_test("hold", err_mark);

    // one word too many, the last one is dropped
    err_mark = errors;
    set_hold(1'b1);
    for (int k = 0; k <= `QUEUE_DEPTH; k++) send_entry((12 + k) % TABLE_N, k < `QUEUE_DEPTH);
    idle(HOLD_WAIT);
    if (overflow !== 1'b1) begin
      errors++;
      $display("FAIL overflow: got 0x%h, expected 0x1", overflow);
    end
    set_hold(1'b0);
    wait_drain();
    send_entry(17, 1'b1);   // its pc skips the dropped word
    wait_drain();
    finish_test("overflow", err_mark);

    idle(2);
    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
fetch_unit.sv
inst_queue.sv
decoder.sv
decode_stage.sv
decode_top.sv
tb_clkgen.sv
decode_assert.sv
decode_tb.sv
